// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module exec_cluster_tb \
		-f compile.f -Mdir obj_dir
	./obj_dir/Vexec_cluster_tb 2>&1 | tee sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
+incdir+verilog
verilog/rv_alu_pkg.sv
verilog/rs_pkg.sv
verilog/phys_reg_file.sv
verilog/reservation_station.sv
verilog/dispatch_stage.sv
verilog/exec_alu.sv
verilog/exec_cluster.sv
tests/exec_cluster_properties.sv
tests/exec_cluster_tb.sv

// ==== tests/exec_cluster_golden.txt ====
# lane op use_imm imm(hex) src_a src_b dest expected(hex)
# op: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 sll, 6 srl, 7 slt
0 0 1 00000005 0 0 1 00000005
1 1 1 00000003 0 0 2 fffffffd
2 2 1 ffffffff 0 0 3 00000000
0 3 1 12345678 0 0 4 12345678
1 4 1 a5a5a5a5 0 0 5 a5a5a5a5
2 5 1 00000004 0 0 6 00000000
0 6 1 0000001f 0 0 7 00000000
1 7 1 00000001 0 0 8 00000001
2 7 1 ffffffff 0 0 9 00000000
2 0 1 7fffffff 0 0 10 7fffffff
0 0 1 00000010 1 0 11 00000015
1 5 1 00000003 11 0 12 000000a8
2 1 0 00000000 12 1 13 000000a3
0 4 0 00000000 13 5 14 a5a5a506
1 6 1 00000004 14 0 15 0a5a5a50
2 7 0 00000000 2 15 16 00000001
0 3 0 00000000 16 12 17 000000a9
1 2 0 00000000 17 4 18 00000028
2 0 0 00000000 18 10 19 80000027
0 7 0 00000000 19 0 20 00000001
1 1 0 00000000 0 19 21 7fffffd9
0 0 1 00000100 21 0 22 800000d9
1 6 0 00000000 22 8 23 4000006c
1 0 1 00000001 23 0 24 4000006d
1 4 1 0000ffff 24 0 25 4000ff92
2 5 0 00000000 25 9 26 4000ff92
2 1 0 00000000 26 25 27 00000000
0 7 0 00000000 27 2 28 00000000
0 7 0 00000000 2 27 29 00000001
1 0 0 00000000 1 4 30 1234567d
2 3 0 00000000 5 3 31 a5a5a5a5
0 5 0 00000000 8 15 32 00010000
1 6 0 00000000 10 29 33 3fffffff
2 4 0 00000000 30 33 34 2dcba982

// ==== tests/exec_cluster_properties.sv ====
`timescale 1ns/1ns
`include "backend_defs.svh"

module exec_cluster_properties #(
    parameter rs_pkg::tag_t LANE_TAG = 2'd0   // Lane of the bound station
) (
    input logic              clk,
    input logic              rst,
    input rs_pkg::rs_state_t state,
    input rs_pkg::tag_t      a_tag,
    input rs_pkg::tag_t      b_tag,
    input logic              issue_valid,
    input logic              dispatch_ready,
    input logic [2:0]        cdb_valid
);

    logic own_cdb;

    assign own_cdb = cdb_valid[LANE_TAG];   // Channel driven by this lane's ALU

    // ==============================
    // Station and channel checks
    // ==============================
    issue_tags_ready: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> (a_tag == `TAG_READY && b_tag == `TAG_READY))
        else $error("lane %0d issued with an operand still pending", LANE_TAG);

    cdb_after_issue: assert property (@(posedge clk) disable iff (rst)
        1'b1 |=> (own_cdb == $past(issue_valid)))
        else $error("lane %0d broadcast out of step with issue", LANE_TAG);

    // A waiting station keeps its lane busy until it has issued
    wait_holds_lane: assert property (@(posedge clk) disable iff (rst)
        (state == rs_pkg::RS_WAIT) |=> !dispatch_ready)
        else $error("lane %0d freed while an operand was pending", LANE_TAG);

    quiet_in_reset: assert property (@(posedge clk)
        rst |=> !own_cdb)
        else $error("lane %0d broadcast during reset", LANE_TAG);

endmodule

// ==== tests/exec_cluster_tb.sv ====
`timescale 1ns/1ns
`include "backend_defs.svh"

module exec_cluster_tb;

    localparam int READY_TIMEOUT = 100;   // Cycles a lane may refuse a record
    localparam int DRAIN_TIMEOUT = 200;   // Cycles to see every broadcast

    logic                clk;
    logic                rst;
    logic                dispatch_valid [3];
    logic                dispatch_ready [3];
    logic                use_imm [3];
    rv_alu_pkg::alu_op_t op [3];
    rs_pkg::word_t       imm [3];
    rs_pkg::preg_t       src_a [3], src_b [3], dest [3];
    logic                cdb_valid [3];
    rs_pkg::preg_t       cdb_dest [3];
    rs_pkg::word_t       cdb_data [3];

    // ==============================
    // Golden records and scoreboard
    // ==============================
    int            nrec;
    int            rec_lane [`NUM_PREGS];
    int            rec_op [`NUM_PREGS];
    logic          rec_use_imm [`NUM_PREGS];
    rs_pkg::word_t rec_imm [`NUM_PREGS];
    rs_pkg::preg_t rec_a [`NUM_PREGS], rec_b [`NUM_PREGS], rec_dest [`NUM_PREGS];
    rs_pkg::word_t rec_exp [`NUM_PREGS];
    int            rec_of [`NUM_PREGS];       // Record index by dest, -1 if none
    logic          dispatched [`NUM_PREGS];
    logic          seen [`NUM_PREGS];
    time           seen_at [`NUM_PREGS];      // Broadcast time per dest
    int            beats;
    integer        seed;

    exec_cluster i_exec_cluster (
        .clk(clk), .rst(rst),
        .dispatch_valid_0(dispatch_valid[0]), .use_imm_0(use_imm[0]),
        .dispatch_ready_0(dispatch_ready[0]), .op_0(op[0]), .imm_0(imm[0]),
        .src_a_0(src_a[0]), .src_b_0(src_b[0]), .dest_0(dest[0]),
        .dispatch_valid_1(dispatch_valid[1]), .use_imm_1(use_imm[1]),
        .dispatch_ready_1(dispatch_ready[1]), .op_1(op[1]), .imm_1(imm[1]),
        .src_a_1(src_a[1]), .src_b_1(src_b[1]), .dest_1(dest[1]),
        .dispatch_valid_2(dispatch_valid[2]), .use_imm_2(use_imm[2]),
        .dispatch_ready_2(dispatch_ready[2]), .op_2(op[2]), .imm_2(imm[2]),
        .src_a_2(src_a[2]), .src_b_2(src_b[2]), .dest_2(dest[2]),
        .cdb_valid_0(cdb_valid[0]), .cdb_valid_1(cdb_valid[1]), .cdb_valid_2(cdb_valid[2]),
        .cdb_dest_0(cdb_dest[0]), .cdb_dest_1(cdb_dest[1]), .cdb_dest_2(cdb_dest[2]),
        .cdb_data_0(cdb_data[0]), .cdb_data_1(cdb_data[1]), .cdb_data_2(cdb_data[2])
    );

    // Station checks, one copy per lane
    bind reservation_station exec_cluster_properties #(.LANE_TAG(LANE_TAG)) i_props (
        .clk(clk), .rst(rst), .state(state_q), .a_tag(a_tag_q), .b_tag(b_tag_q),
        .issue_valid(issue_valid), .dispatch_ready(dispatch_ready),
        .cdb_valid({cdb_valid_2, cdb_valid_1, cdb_valid_0})
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_result(input rs_pkg::preg_t dest_reg, input rs_pkg::word_t got,
                                  input rs_pkg::word_t expected);
        if (got !== expected)
            abort_run($sformatf("FAILED at %0t: cdb_data for p%0d got %h expected %h",
                                $time, dest_reg, got, expected));
    endtask

    task automatic compare_ready(input int lane, input logic got, input logic expected);
        if (got !== expected)
            abort_run($sformatf("FAILED at %0t: dispatch_ready_%0d got %b expected %b",
                                $time, lane, got, expected));
    endtask

    task automatic load_golden();
        int    fd;
        int    code;
        string line;
        fd = $fopen("tests/exec_cluster_golden.txt", "r");
        if (fd == 0)
            abort_run("could not open the golden file");
        nrec = 0;
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 1 && line.getc(0) != "#") begin   // Skip blanks and column notes
                code = $sscanf(line, "%d %d %d %h %d %d %d %h", rec_lane[nrec], rec_op[nrec],
                               rec_use_imm[nrec], rec_imm[nrec], rec_a[nrec], rec_b[nrec],
                               rec_dest[nrec], rec_exp[nrec]);
                if (code != 8)
                    abort_run($sformatf("malformed golden line: %s", line));
                if (rec_dest[nrec] == '0 || rec_of[rec_dest[nrec]] >= 0)
                    abort_run($sformatf("golden record %0d reuses or zeroes its dest", nrec));
                rec_of[rec_dest[nrec]] = nrec;
                nrec++;
            end
        end
        $fclose(fd);
        if (nrec == 0)
            abort_run("the golden file holds no records");
    endtask

    // Hold valid until the lane takes it, then drop it
    task automatic send_record(input int r);
        int ln;
        int waited;
        ln = rec_lane[r];
        dispatched[rec_dest[r]] = 1'b1;
        dispatch_valid[ln] = 1'b1;
        op[ln]      = rv_alu_pkg::alu_op_t'(rec_op[r]);
        use_imm[ln] = rec_use_imm[r];
        imm[ln]     = rec_imm[r];
        src_a[ln]   = rec_a[r];
        src_b[ln]   = rec_b[r];
        dest[ln]    = rec_dest[r];
        waited = 0;
        while (!dispatch_ready[ln]) begin
            @(negedge clk);
            waited++;
            if (waited > READY_TIMEOUT)
                abort_run($sformatf("lane %0d never took record %0d", ln, r));
        end
        @(negedge clk);                       // Accepted at the edge just passed
        dispatch_valid[ln] = 1'b0;
        compare_ready(ln, dispatch_ready[ln], 1'b0);   // Station now busy
    endtask

    task automatic check_beat(input int ch, input rs_pkg::preg_t d, input rs_pkg::word_t got);
        int r;
        r = rec_of[d];
        if (r < 0 || !dispatched[d])
            abort_run($sformatf("unexpected broadcast for p%0d on channel %0d", d, ch));
        if (seen[d])
            abort_run($sformatf("p%0d was broadcast a second time", d));
        if (rec_lane[r] != ch)
            abort_run($sformatf("p%0d came on channel %0d, not its lane", d, ch));
        // Producers must have broadcast in an earlier cycle
        if (rec_a[r] != '0 && rec_of[rec_a[r]] >= 0 &&
            !(seen[rec_a[r]] && seen_at[rec_a[r]] < $time))
            abort_run($sformatf("p%0d broadcast before its producer p%0d", d, rec_a[r]));
        if (!rec_use_imm[r] && rec_b[r] != '0 && rec_of[rec_b[r]] >= 0 &&
            !(seen[rec_b[r]] && seen_at[rec_b[r]] < $time))
            abort_run($sformatf("p%0d broadcast before its producer p%0d", d, rec_b[r]));
        compare_result(d, got, rec_exp[r]);
        seen[d]    = 1'b1;
        seen_at[d] = $time;
        beats++;
    endtask

    // Result bus monitor, outputs are settled at the falling edge
    initial begin : cdb_monitor
        forever begin
            @(negedge clk);
            for (int ch = 0; ch < 3; ch++)
                if (cdb_valid[ch] === 1'b1)
                    check_beat(ch, cdb_dest[ch], cdb_data[ch]);
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    initial begin : stimulus
        int gap;
        int waited;
        rst   = 1'b1;
        beats = 0;
        seed  = 32'h3888;
        for (int ln = 0; ln < 3; ln++) begin
            dispatch_valid[ln] = 1'b0;
            use_imm[ln] = 1'b0;
            op[ln]      = rv_alu_pkg::ALU_ADD;
            imm[ln]     = '0;
            src_a[ln]   = '0;
            src_b[ln]   = '0;
            dest[ln]    = '0;
        end
        for (int i = 0; i < `NUM_PREGS; i++) begin
            rec_of[i]     = -1;
            dispatched[i] = 1'b0;
            seen[i]       = 1'b0;
            seen_at[i]    = 0;
        end
        load_golden();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int ln = 0; ln < 3; ln++)
            compare_ready(ln, dispatch_ready[ln], 1'b1);   // All stations empty
        for (int r = 0; r < nrec; r++) begin
            send_record(r);
            gap = $random(seed) & 3;          // Idle gap of 0 to 3 cycles
            repeat (gap) @(negedge clk);
        end
        waited = 0;
        while (beats < nrec) begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT)
                abort_run($sformatf("timeout with %0d of %0d results broadcast", beats, nrec));
        end
        repeat (4) @(negedge clk);            // Room for a stray late beat
        if (beats == nrec) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run($sformatf("%0d broadcasts seen for %0d records", beats, nrec));
        end
    end

endmodule

// ==== verilog/backend_defs.svh ====
`ifndef BACKEND_DEFS_SVH
`define BACKEND_DEFS_SVH

// ==============================
// Datapath and register file sizes
// ==============================
`define XLEN      32        // Integer data width
`define PREG_W    6         // Physical register address bits
`define NUM_PREGS 64        // Entries in the shared register file
`define TAG_W     2         // Producer tag width

// Tags 0..2 name the producing lane
`define TAG_READY 2'b11     // Value present, nothing pending

`endif

// ==== verilog/dispatch_stage.sv ====
`timescale 1ns/1ns
`include "backend_defs.svh"

module dispatch_stage (
    input  logic                clk,
    input  logic                rst,
    // Dispatch, lane 0
    input  logic                dispatch_valid_0, use_imm_0,
    output logic                dispatch_ready_0,
    input  rv_alu_pkg::alu_op_t op_0,
    input  rs_pkg::word_t       imm_0,
    input  rs_pkg::preg_t       src_a_0, src_b_0, dest_0,
    // Dispatch, lane 1
    input  logic                dispatch_valid_1, use_imm_1,
    output logic                dispatch_ready_1,
    input  rv_alu_pkg::alu_op_t op_1,
    input  rs_pkg::word_t       imm_1,
    input  rs_pkg::preg_t       src_a_1, src_b_1, dest_1,
    // Dispatch, lane 2
    input  logic                dispatch_valid_2, use_imm_2,
    output logic                dispatch_ready_2,
    input  rv_alu_pkg::alu_op_t op_2,
    input  rs_pkg::word_t       imm_2,
    input  rs_pkg::preg_t       src_a_2, src_b_2, dest_2,
    // Issue to the ALUs
    output logic                issue_valid_0, issue_valid_1, issue_valid_2,
    output rv_alu_pkg::alu_op_t issue_op_0, issue_op_1, issue_op_2,
    output rs_pkg::word_t       issue_a_0, issue_a_1, issue_a_2,
    output rs_pkg::word_t       issue_b_0, issue_b_1, issue_b_2,
    output rs_pkg::preg_t       issue_dest_0, issue_dest_1, issue_dest_2,
    // Result bus loopback
    input  logic                cdb_valid_0, cdb_valid_1, cdb_valid_2,
    input  rs_pkg::preg_t       cdb_dest_0, cdb_dest_1, cdb_dest_2,
    input  rs_pkg::word_t       cdb_data_0, cdb_data_1, cdb_data_2
);

    rs_pkg::word_t rd_data_a_0, rd_data_b_0, rd_data_a_1, rd_data_b_1;
    rs_pkg::word_t rd_data_a_2, rd_data_b_2;
    rs_pkg::tag_t  rd_tag_a_0, rd_tag_b_0, rd_tag_a_1, rd_tag_b_1;
    rs_pkg::tag_t  rd_tag_a_2, rd_tag_b_2;
    rs_pkg::word_t b_data_0, b_data_1, b_data_2;
    rs_pkg::tag_t  b_tag_0, b_tag_1, b_tag_2;
    logic          alloc_en_0, alloc_en_1, alloc_en_2;

    // Only an accepted dispatch re-tags its destination
    assign alloc_en_0 = dispatch_valid_0 && dispatch_ready_0;
    assign alloc_en_1 = dispatch_valid_1 && dispatch_ready_1;
    assign alloc_en_2 = dispatch_valid_2 && dispatch_ready_2;

    // Operand B mux, an immediate is always present
    assign b_data_0 = use_imm_0 ? imm_0 : rd_data_b_0;
    assign b_data_1 = use_imm_1 ? imm_1 : rd_data_b_1;
    assign b_data_2 = use_imm_2 ? imm_2 : rd_data_b_2;
    assign b_tag_0  = use_imm_0 ? `TAG_READY : rd_tag_b_0;
    assign b_tag_1  = use_imm_1 ? `TAG_READY : rd_tag_b_1;
    assign b_tag_2  = use_imm_2 ? `TAG_READY : rd_tag_b_2;

    // ==============================
    // Shared register file
    // ==============================
    phys_reg_file i_prf (
        .clk(clk), .rst(rst),
        .rd_addr_a_0(src_a_0), .rd_addr_b_0(src_b_0),
        .rd_data_a_0(rd_data_a_0), .rd_data_b_0(rd_data_b_0),
        .rd_tag_a_0(rd_tag_a_0), .rd_tag_b_0(rd_tag_b_0),
        .alloc_en_0(alloc_en_0), .alloc_addr_0(dest_0),
        .cdb_valid_0(cdb_valid_0), .cdb_dest_0(cdb_dest_0), .cdb_data_0(cdb_data_0),
        .rd_addr_a_1(src_a_1), .rd_addr_b_1(src_b_1),
        .rd_data_a_1(rd_data_a_1), .rd_data_b_1(rd_data_b_1),
        .rd_tag_a_1(rd_tag_a_1), .rd_tag_b_1(rd_tag_b_1),
        .alloc_en_1(alloc_en_1), .alloc_addr_1(dest_1),
        .cdb_valid_1(cdb_valid_1), .cdb_dest_1(cdb_dest_1), .cdb_data_1(cdb_data_1),
        .rd_addr_a_2(src_a_2), .rd_addr_b_2(src_b_2),
        .rd_data_a_2(rd_data_a_2), .rd_data_b_2(rd_data_b_2),
        .rd_tag_a_2(rd_tag_a_2), .rd_tag_b_2(rd_tag_b_2),
        .alloc_en_2(alloc_en_2), .alloc_addr_2(dest_2),
        .cdb_valid_2(cdb_valid_2), .cdb_dest_2(cdb_dest_2), .cdb_data_2(cdb_data_2)
    );

    // ==============================
    // One station per lane
    // ==============================
    reservation_station #(.LANE_TAG(2'd0)) rs_0 (
        .clk(clk), .rst(rst),
        .dispatch_valid(dispatch_valid_0), .dispatch_ready(dispatch_ready_0),
        .op(op_0), .dest(dest_0),
        .a_data(rd_data_a_0), .b_data(b_data_0), .a_tag(rd_tag_a_0), .b_tag(b_tag_0),
        .cdb_valid_0(cdb_valid_0), .cdb_valid_1(cdb_valid_1), .cdb_valid_2(cdb_valid_2),
        .cdb_data_0(cdb_data_0), .cdb_data_1(cdb_data_1), .cdb_data_2(cdb_data_2),
        .issue_valid(issue_valid_0), .issue_op(issue_op_0),
        .issue_a(issue_a_0), .issue_b(issue_b_0), .issue_dest(issue_dest_0)
    );

    reservation_station #(.LANE_TAG(2'd1)) rs_1 (
        .clk(clk), .rst(rst),
        .dispatch_valid(dispatch_valid_1), .dispatch_ready(dispatch_ready_1),
        .op(op_1), .dest(dest_1),
        .a_data(rd_data_a_1), .b_data(b_data_1), .a_tag(rd_tag_a_1), .b_tag(b_tag_1),
        .cdb_valid_0(cdb_valid_0), .cdb_valid_1(cdb_valid_1), .cdb_valid_2(cdb_valid_2),
        .cdb_data_0(cdb_data_0), .cdb_data_1(cdb_data_1), .cdb_data_2(cdb_data_2),
        .issue_valid(issue_valid_1), .issue_op(issue_op_1),
        .issue_a(issue_a_1), .issue_b(issue_b_1), .issue_dest(issue_dest_1)
    );

    reservation_station #(.LANE_TAG(2'd2)) rs_2 (
        .clk(clk), .rst(rst),
        .dispatch_valid(dispatch_valid_2), .dispatch_ready(dispatch_ready_2),
        .op(op_2), .dest(dest_2),
        .a_data(rd_data_a_2), .b_data(b_data_2), .a_tag(rd_tag_a_2), .b_tag(b_tag_2),
        .cdb_valid_0(cdb_valid_0), .cdb_valid_1(cdb_valid_1), .cdb_valid_2(cdb_valid_2),
        .cdb_data_0(cdb_data_0), .cdb_data_1(cdb_data_1), .cdb_data_2(cdb_data_2),
        .issue_valid(issue_valid_2), .issue_op(issue_op_2),
        .issue_a(issue_a_2), .issue_b(issue_b_2), .issue_dest(issue_dest_2)
    );

endmodule

// ==== verilog/exec_alu.sv ====
`timescale 1ns/1ns

module exec_alu (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue_valid,
    input  rv_alu_pkg::alu_op_t issue_op,
    input  rs_pkg::word_t       issue_a,
    input  rs_pkg::word_t       issue_b,
    input  rs_pkg::preg_t       issue_dest,
    output logic                cdb_valid,
    output rs_pkg::preg_t       cdb_dest,
    output rs_pkg::word_t       cdb_data
);

    rs_pkg::word_t result;

    always_comb begin
        case (issue_op)
            rv_alu_pkg::ALU_ADD: result = issue_a + issue_b;
            rv_alu_pkg::ALU_SUB: result = issue_a - issue_b;
            rv_alu_pkg::ALU_AND: result = issue_a & issue_b;
            rv_alu_pkg::ALU_OR:  result = issue_a | issue_b;
            rv_alu_pkg::ALU_XOR: result = issue_a ^ issue_b;
            rv_alu_pkg::ALU_SLL: result = issue_a << issue_b[4:0];
            rv_alu_pkg::ALU_SRL: result = issue_a >> issue_b[4:0];
            rv_alu_pkg::ALU_SLT: result = ($signed(issue_a) < $signed(issue_b)) ? 1 : 0;
            default:             result = '0;
        endcase
    end

    // Broadcast stage, one beat per issue
    always_ff @(posedge clk) begin
        if (rst)
            cdb_valid <= 1'b0;
        else
            cdb_valid <= issue_valid;
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            cdb_dest <= issue_dest;
            cdb_data <= result;
        end
    end

endmodule

// ==== verilog/exec_cluster.sv ====
`timescale 1ns/1ns

module exec_cluster (
    input  logic                clk,
    input  logic                rst,
    // Dispatch, lane 0
    input  logic                dispatch_valid_0, use_imm_0,
    output logic                dispatch_ready_0,
    input  rv_alu_pkg::alu_op_t op_0,
    input  rs_pkg::word_t       imm_0,
    input  rs_pkg::preg_t       src_a_0, src_b_0, dest_0,
    // Dispatch, lane 1
    input  logic                dispatch_valid_1, use_imm_1,
    output logic                dispatch_ready_1,
    input  rv_alu_pkg::alu_op_t op_1,
    input  rs_pkg::word_t       imm_1,
    input  rs_pkg::preg_t       src_a_1, src_b_1, dest_1,
    // Dispatch, lane 2
    input  logic                dispatch_valid_2, use_imm_2,
    output logic                dispatch_ready_2,
    input  rv_alu_pkg::alu_op_t op_2,
    input  rs_pkg::word_t       imm_2,
    input  rs_pkg::preg_t       src_a_2, src_b_2, dest_2,
    // Result bus, channel n carries lane n
    output logic                cdb_valid_0, cdb_valid_1, cdb_valid_2,
    output rs_pkg::preg_t       cdb_dest_0, cdb_dest_1, cdb_dest_2,
    output rs_pkg::word_t       cdb_data_0, cdb_data_1, cdb_data_2
);

    logic                issue_valid_0, issue_valid_1, issue_valid_2;
    rv_alu_pkg::alu_op_t issue_op_0, issue_op_1, issue_op_2;
    rs_pkg::word_t       issue_a_0, issue_a_1, issue_a_2;
    rs_pkg::word_t       issue_b_0, issue_b_1, issue_b_2;
    rs_pkg::preg_t       issue_dest_0, issue_dest_1, issue_dest_2;

    dispatch_stage i_dispatch (
        .clk(clk), .rst(rst),
        .dispatch_valid_0(dispatch_valid_0), .use_imm_0(use_imm_0),
        .dispatch_ready_0(dispatch_ready_0), .op_0(op_0), .imm_0(imm_0),
        .src_a_0(src_a_0), .src_b_0(src_b_0), .dest_0(dest_0),
        .dispatch_valid_1(dispatch_valid_1), .use_imm_1(use_imm_1),
        .dispatch_ready_1(dispatch_ready_1), .op_1(op_1), .imm_1(imm_1),
        .src_a_1(src_a_1), .src_b_1(src_b_1), .dest_1(dest_1),
        .dispatch_valid_2(dispatch_valid_2), .use_imm_2(use_imm_2),
        .dispatch_ready_2(dispatch_ready_2), .op_2(op_2), .imm_2(imm_2),
        .src_a_2(src_a_2), .src_b_2(src_b_2), .dest_2(dest_2),
        .issue_valid_0(issue_valid_0), .issue_valid_1(issue_valid_1),
        .issue_valid_2(issue_valid_2),
        .issue_op_0(issue_op_0), .issue_op_1(issue_op_1), .issue_op_2(issue_op_2),
        .issue_a_0(issue_a_0), .issue_a_1(issue_a_1), .issue_a_2(issue_a_2),
        .issue_b_0(issue_b_0), .issue_b_1(issue_b_1), .issue_b_2(issue_b_2),
        .issue_dest_0(issue_dest_0), .issue_dest_1(issue_dest_1),
        .issue_dest_2(issue_dest_2),
        .cdb_valid_0(cdb_valid_0), .cdb_valid_1(cdb_valid_1), .cdb_valid_2(cdb_valid_2),
        .cdb_dest_0(cdb_dest_0), .cdb_dest_1(cdb_dest_1), .cdb_dest_2(cdb_dest_2),
        .cdb_data_0(cdb_data_0), .cdb_data_1(cdb_data_1), .cdb_data_2(cdb_data_2)
    );

    // ==============================
    // ALUs, outputs loop back as the result bus
    // ==============================
    exec_alu i_alu_0 (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid_0), .issue_op(issue_op_0),
        .issue_a(issue_a_0), .issue_b(issue_b_0), .issue_dest(issue_dest_0),
        .cdb_valid(cdb_valid_0), .cdb_dest(cdb_dest_0), .cdb_data(cdb_data_0)
    );

    exec_alu i_alu_1 (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid_1), .issue_op(issue_op_1),
        .issue_a(issue_a_1), .issue_b(issue_b_1), .issue_dest(issue_dest_1),
        .cdb_valid(cdb_valid_1), .cdb_dest(cdb_dest_1), .cdb_data(cdb_data_1)
    );

    exec_alu i_alu_2 (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid_2), .issue_op(issue_op_2),
        .issue_a(issue_a_2), .issue_b(issue_b_2), .issue_dest(issue_dest_2),
        .cdb_valid(cdb_valid_2), .cdb_dest(cdb_dest_2), .cdb_data(cdb_data_2)
    );

endmodule

// ==== verilog/phys_reg_file.sv ====
`timescale 1ns/1ns
`include "backend_defs.svh"

module phys_reg_file (
    input  logic          clk,
    input  logic          rst,
    // Lane 0
    input  rs_pkg::preg_t rd_addr_a_0, rd_addr_b_0,
    output rs_pkg::word_t rd_data_a_0, rd_data_b_0,
    output rs_pkg::tag_t  rd_tag_a_0, rd_tag_b_0,
    input  logic          alloc_en_0,
    input  rs_pkg::preg_t alloc_addr_0,
    input  logic          cdb_valid_0,
    input  rs_pkg::preg_t cdb_dest_0,
    input  rs_pkg::word_t cdb_data_0,
    // Lane 1
    input  rs_pkg::preg_t rd_addr_a_1, rd_addr_b_1,
    output rs_pkg::word_t rd_data_a_1, rd_data_b_1,
    output rs_pkg::tag_t  rd_tag_a_1, rd_tag_b_1,
    input  logic          alloc_en_1,
    input  rs_pkg::preg_t alloc_addr_1,
    input  logic          cdb_valid_1,
    input  rs_pkg::preg_t cdb_dest_1,
    input  rs_pkg::word_t cdb_data_1,
    // Lane 2
    input  rs_pkg::preg_t rd_addr_a_2, rd_addr_b_2,
    output rs_pkg::word_t rd_data_a_2, rd_data_b_2,
    output rs_pkg::tag_t  rd_tag_a_2, rd_tag_b_2,
    input  logic          alloc_en_2,
    input  rs_pkg::preg_t alloc_addr_2,
    input  logic          cdb_valid_2,
    input  rs_pkg::preg_t cdb_dest_2,
    input  rs_pkg::word_t cdb_data_2
);

    rs_pkg::word_t data_q [`NUM_PREGS];
    rs_pkg::tag_t  tag_q  [`NUM_PREGS];   // Pending producer per entry

    // Per-lane views, index is the lane
    logic [2:0]    cv;
    logic [2:0]    av;
    rs_pkg::preg_t cd [3];
    rs_pkg::word_t cw [3];
    rs_pkg::preg_t aa [3];

    // Six read ports, A then B for each lane
    rs_pkg::preg_t ra [6];
    rs_pkg::word_t rd [6];
    rs_pkg::tag_t  rt [6];

    assign cv = {cdb_valid_2, cdb_valid_1, cdb_valid_0};
    assign av = {alloc_en_2, alloc_en_1, alloc_en_0};
    assign cd = '{cdb_dest_0, cdb_dest_1, cdb_dest_2};
    assign cw = '{cdb_data_0, cdb_data_1, cdb_data_2};
    assign aa = '{alloc_addr_0, alloc_addr_1, alloc_addr_2};
    assign ra = '{rd_addr_a_0, rd_addr_b_0, rd_addr_a_1, rd_addr_b_1, rd_addr_a_2, rd_addr_b_2};

    // ==============================
    // Commit and allocation
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_PREGS; i++) begin
                data_q[i] <= '0;
                tag_q[i]  <= `TAG_READY;
            end
        end else begin
            // Commit only when the entry still waits on this lane
            for (int n = 0; n < 3; n++) begin
                if (cv[n] && cd[n] != '0 && tag_q[cd[n]] == rs_pkg::tag_t'(n)) begin
                    data_q[cd[n]] <= cw[n];
                    tag_q[cd[n]]  <= `TAG_READY;
                end
            end
            // Later assignment, so allocation beats a commit to the same entry
            for (int n = 0; n < 3; n++) begin
                if (av[n] && aa[n] != '0)
                    tag_q[aa[n]] <= rs_pkg::tag_t'(n);
            end
        end
    end

    // ==============================
    // Reads with result-bus bypass
    // ==============================
    always_comb begin
        for (int i = 0; i < 6; i++) begin
            rd[i] = data_q[ra[i]];
            rt[i] = tag_q[ra[i]];
            for (int n = 0; n < 3; n++) begin
                if (cv[n] && cd[n] == ra[i] && tag_q[ra[i]] == rs_pkg::tag_t'(n)) begin
                    rd[i] = cw[n];            // Result lands this edge
                    rt[i] = `TAG_READY;
                end
            end
            if (ra[i] == '0) begin            // p0 is hardwired zero
                rd[i] = '0;
                rt[i] = `TAG_READY;
            end
        end
    end

    assign rd_data_a_0 = rd[0];
    assign rd_data_b_0 = rd[1];
    assign rd_data_a_1 = rd[2];
    assign rd_data_b_1 = rd[3];
    assign rd_data_a_2 = rd[4];
    assign rd_data_b_2 = rd[5];
    assign rd_tag_a_0  = rt[0];
    assign rd_tag_b_0  = rt[1];
    assign rd_tag_a_1  = rt[2];
    assign rd_tag_b_1  = rt[3];
    assign rd_tag_a_2  = rt[4];
    assign rd_tag_b_2  = rt[5];

endmodule

// ==== verilog/reservation_station.sv ====
`timescale 1ns/1ns
`include "backend_defs.svh"

module reservation_station #(
    parameter rs_pkg::tag_t LANE_TAG = 2'd0   // Lane this station feeds
) (
    input  logic                clk,
    input  logic                rst,
    // Dispatch side
    input  logic                dispatch_valid,
    output logic                dispatch_ready,
    input  rv_alu_pkg::alu_op_t op,
    input  rs_pkg::preg_t       dest,
    input  rs_pkg::word_t       a_data, b_data,
    input  rs_pkg::tag_t        a_tag, b_tag,
    // Result bus snoop
    input  logic                cdb_valid_0, cdb_valid_1, cdb_valid_2,
    input  rs_pkg::word_t       cdb_data_0, cdb_data_1, cdb_data_2,
    // Issue to the ALU
    output logic                issue_valid,
    output rv_alu_pkg::alu_op_t issue_op,
    output rs_pkg::word_t       issue_a, issue_b,
    output rs_pkg::preg_t       issue_dest
);

    rs_pkg::rs_state_t state_q;
    rs_pkg::tag_t      a_tag_q, b_tag_q;   // Producer still owed per operand

    // Channel views indexed by tag, slot 3 is the ready tag and never hits
    logic [3:0]    cv;
    rs_pkg::word_t cw [4];
    logic          a_hit, b_hit;
    logic          a_done, b_done;

    assign cv = {1'b0, cdb_valid_2, cdb_valid_1, cdb_valid_0};
    assign cw = '{cdb_data_0, cdb_data_1, cdb_data_2, '0};

    assign a_hit  = cv[a_tag_q];
    assign b_hit  = cv[b_tag_q];
    assign a_done = a_hit || a_tag_q == `TAG_READY;
    assign b_done = b_hit || b_tag_q == `TAG_READY;

    assign dispatch_ready = state_q == rs_pkg::RS_EMPTY;
    assign issue_valid    = state_q == rs_pkg::RS_READY;   // Single cycle

    // ==============================
    // Occupancy FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= rs_pkg::RS_EMPTY;
        end else begin
            case (state_q)
                rs_pkg::RS_EMPTY: begin
                    if (dispatch_valid)
                        state_q <= (a_tag == `TAG_READY && b_tag == `TAG_READY) ?
                                   rs_pkg::RS_READY : rs_pkg::RS_WAIT;
                end
                rs_pkg::RS_WAIT: begin
                    if (a_done && b_done)
                        state_q <= rs_pkg::RS_READY;   // Issue next cycle
                end
                rs_pkg::RS_READY: state_q <= rs_pkg::RS_EMPTY;   // ALU always takes it
                default:          state_q <= rs_pkg::RS_EMPTY;
            endcase
        end
    end

    // Operand capture and wake-up
    always_ff @(posedge clk) begin
        if (dispatch_valid && dispatch_ready) begin
            issue_op   <= op;
            issue_dest <= dest;
            issue_a    <= a_data;
            issue_b    <= b_data;
            a_tag_q    <= a_tag;
            b_tag_q    <= b_tag;
        end else if (state_q == rs_pkg::RS_WAIT) begin
            if (a_hit) begin
                issue_a <= cw[a_tag_q];
                a_tag_q <= `TAG_READY;
            end
            if (b_hit) begin                 // Same producer for both is fine
                issue_b <= cw[b_tag_q];
                b_tag_q <= `TAG_READY;
            end
        end
    end

endmodule

// ==== verilog/rs_pkg.sv ====
`include "backend_defs.svh"

package rs_pkg;

    // ==============================
    // Datapath types
    // ==============================
    typedef logic [`XLEN-1:0]   word_t;   // Data word
    typedef logic [`PREG_W-1:0] preg_t;   // Physical register address
    typedef logic [`TAG_W-1:0]  tag_t;    // Producer lane or ready

    // Reservation station occupancy
    typedef enum logic [1:0] {
        RS_EMPTY = 2'd0,   // Free, accepts dispatch
        RS_WAIT  = 2'd1,   // Holding, operand still pending
        RS_READY = 2'd2    // Both operands present, issues this cycle
    } rs_state_t;

endpackage

// ==== verilog/rv_alu_pkg.sv ====
package rv_alu_pkg;

    // Integer ALU operations, RV32I subset
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,   // Shift amount from B[4:0]
        ALU_SRL = 4'd6,   // Logical, zero fill
        ALU_SLT = 4'd7    // Signed compare, result 1 or 0
    } alu_op_t;

endpackage
